// File: verilog.f
+incdir+hdl
+incdir+verif
hdl/axi_chan_pkg.sv
hdl/mux_route_pkg.sv
hdl/req_arbiter.sv
hdl/w_route_buffer.sv
hdl/resp_router.sv
hdl/axi_master_mux.sv
verif/tb_axi_master_mux.sv

// File: Makefile
# Verilator flow for the AXI master mux

TOP := tb_axi_master_mux
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module axi_master_mux

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qx "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verif/tb_tasks.svh
/*
 * Directed tests, included inside the testbench module.
 * They run in this order. AR and AW pointer positions depend on the tests before.
 */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic reset_state_idle();
    @(negedge clk_i);
    src_w_valid_i = '1;  // W offered with no write open
    m_w_ready_i   = 1'b1;
    #1;
    expect_eq(64'(m_ar_valid_o), 64'd0, "AR valid after reset");
    expect_eq(64'(m_aw_valid_o), 64'd0, "AW valid after reset");
    expect_eq(64'(m_w_valid_o), 64'd0, "W valid with empty FIFO");
    expect_eq(64'(src_w_ready_o), 64'd0, "W ready with empty FIFO");
    @(negedge clk_i);
    src_w_valid_i = '0;
    m_w_ready_i   = 1'b0;
endtask

// --------------------------------------------------
// AR arbitration
// --------------------------------------------------
task automatic ar_round_robin();
    @(negedge clk_i);
    for (int s = 0; s < `N_SRC; s++) begin
        src_ar_id_i[s]   = 4'(rand32());
        src_ar_addr_i[s] = rand32();
        src_ar_len_i[s]  = 8'(rand32());
    end
    src_ar_valid_i = '1;
    m_ar_ready_i   = 1'b1;
    for (int k = 0; k < `N_SRC; k++) begin
        #1;
        expect_eq(64'(m_ar_valid_o), 64'd1, "AR valid in round-robin");
        expect_eq(64'(src_ar_ready_o), 64'(onehot(k)), "AR grant order");
        expect_eq(64'({m_ar_id_o, m_ar_addr_o, m_ar_len_o}),
                  64'({src_ar_id_i[k], src_ar_addr_i[k], src_ar_len_i[k]}), "AR payload");
        @(negedge clk_i);
        src_ar_valid_i[k] = 1'b0;  // taken on the last rising edge
    end
    m_ar_ready_i = 1'b0;
endtask

task automatic ar_stall_holds_grant();
    int rest [2];
    rest = '{2, 0};  // pointer sits one past source 1 after its transfer
    @(negedge clk_i);
    src_ar_addr_i[1] = rand32();
    src_ar_addr_i[2] = rand32();
    src_ar_valid_i   = 3'b110;
    for (int c = 0; c < 5; c++) begin
        if (c == 2) begin
            src_ar_valid_i[0] = 1'b1;  // higher priority shows up mid-stall
        end
        #1;
        expect_eq(64'(m_ar_valid_o), 64'd1, "AR valid under back-pressure");
        expect_eq(64'(src_ar_ready_o), 64'd0, "AR ready under back-pressure");
        expect_eq(64'(m_ar_addr_o), 64'(src_ar_addr_i[1]), "AR payload under back-pressure");
        @(negedge clk_i);
    end
    m_ar_ready_i = 1'b1;
    #1;
    expect_eq(64'(src_ar_ready_o), 64'(onehot(1)), "AR grant kept through stall");
    for (int k = 0; k < 2; k++) begin
        @(negedge clk_i);
        src_ar_valid_i[k == 0 ? 1 : rest[0]] = 1'b0;
        #1;
        expect_eq(64'(src_ar_ready_o), 64'(onehot(rest[k])), "AR grant after stall");
    end
    @(negedge clk_i);
    src_ar_valid_i = '0;
    m_ar_ready_i   = 1'b0;
endtask

// --------------------------------------------------
// W routing
// --------------------------------------------------
task automatic w_follows_aw_order();
    logic [63:0] beat_data [3][4];
    logic [7:0]  beat_strb [3][4];
    int          n_beats [3];
    int          idx [3];
    int          order [$];
    int          head;
    int          cycles;
    @(negedge clk_i);
    src_aw_id_i    = '0;
    src_aw_id_i[1] = 4'b1001;  // bypass
    src_aw_id_i[2] = 4'b1100;  // dcache
    for (int s = 1; s < `N_SRC; s++) begin
        src_aw_addr_i[s] = rand32();
        src_aw_len_i[s]  = 8'(rand32());
    end
    src_aw_valid_i = 3'b110;
    m_aw_ready_i   = 1'b1;
    #1;
    expect_eq(64'(src_aw_ready_o), 64'(onehot(1)), "first AW grant");
    expect_eq(64'({m_aw_valid_o, m_aw_id_o, m_aw_addr_o, m_aw_len_o}),
              64'({1'b1, 4'h9, src_aw_addr_i[1], src_aw_len_i[1]}), "first AW payload");
    @(negedge clk_i);
    src_aw_valid_i[1] = 1'b0;
    #1;
    expect_eq(64'(src_aw_ready_o), 64'(onehot(2)), "second AW grant");
    expect_eq(64'({m_aw_valid_o, m_aw_id_o, m_aw_addr_o, m_aw_len_o}),
              64'({1'b1, 4'hc, src_aw_addr_i[2], src_aw_len_i[2]}), "second AW payload");
    @(negedge clk_i);
    src_aw_valid_i = '0;
    m_aw_ready_i   = 1'b0;
    n_beats = '{0, 3, 2};
    idx     = '{0, 0, 0};
    for (int s = 0; s < `N_SRC; s++) begin
        for (int b = 0; b < 4; b++) begin
            beat_data[s][b] = {rand32(), rand32()};
            beat_strb[s][b] = 8'(rand32());
        end
    end
    order  = '{1, 2};  // AW acceptance order
    cycles = 0;
    while (order.size() > 0 && cycles < 40) begin
        for (int s = 1; s < `N_SRC; s++) begin
            src_w_valid_i[s] = (idx[s] < n_beats[s]);
            src_w_data_i[s]  = beat_data[s][idx[s]];
            src_w_strb_i[s]  = beat_strb[s][idx[s]];
            src_w_last_i[s]  = (idx[s] == n_beats[s] - 1);
        end
        m_w_ready_i = 1'(rand32());  // random master stalls
        #1;
        head = order[0];
        expect_eq(64'(m_w_valid_o), 64'd1, "W valid from FIFO head");
        expect_eq(64'(src_w_ready_o), 64'(m_w_ready_i ? onehot(head) : 3'b000), "W ready");
        expect_eq(m_w_data_o, beat_data[head][idx[head]], "W data");
        expect_eq(64'({m_w_strb_o, m_w_last_o}),
                  64'({beat_strb[head][idx[head]], idx[head] == n_beats[head] - 1}),
                  "W strb and last");
        if (m_w_ready_i) begin
            idx[head]++;
            if (idx[head] == n_beats[head]) begin
                void'(order.pop_front());
            end
        end
        cycles++;
        @(negedge clk_i);
    end
    assert (order.size() == 0)
    else begin
        errors++;
        $display("W bursts still open after %0d cycles", cycles);
    end
    src_w_valid_i = '0;
    src_w_last_i  = '0;
    m_w_ready_i   = 1'b0;
endtask

task automatic aw_stops_when_full();
    @(negedge clk_i);
    m_aw_ready_i   = 1'b1;
    src_aw_valid_i = 3'b100;
    for (int k = 0; k <= `W_FIFO_DEPTH; k++) begin
        src_aw_id_i[2] = 4'b1100 | 4'(k);
        #1;
        if (k < `W_FIFO_DEPTH) begin
            expect_eq(64'(src_aw_ready_o), 64'(onehot(2)), "AW ready with FIFO space");
        end else begin
            expect_eq(64'(src_aw_ready_o), 64'd0, "AW ready with FIFO full");
        end
        expect_eq(64'(m_aw_id_o), 64'(src_aw_id_i[2]), "AW id toward master");
        @(negedge clk_i);
    end
    src_w_valid_i = 3'b100;  // single-beat bursts from dcache
    src_w_last_i  = 3'b100;
    m_w_ready_i   = 1'b1;
    #1;
    expect_eq(64'(src_aw_ready_o), 64'd0, "AW ready before burst ends");
    @(negedge clk_i);
    src_w_valid_i = '0;
    #1;
    expect_eq(64'(src_aw_ready_o), 64'(onehot(2)), "AW ready after a burst ends");
    @(negedge clk_i);
    src_aw_valid_i = '0;
    src_w_valid_i  = 3'b100;
    for (int k = 0; k < `W_FIFO_DEPTH; k++) begin
        #1;
        expect_eq(64'(src_w_ready_o), 64'(onehot(2)), "W ready while draining");
        @(negedge clk_i);
    end
    #1;
    expect_eq(64'(src_w_ready_o), 64'd0, "W ready after drain");
    @(negedge clk_i);
    src_w_valid_i = '0;
    src_w_last_i  = '0;
    m_w_ready_i   = 1'b0;
    m_aw_ready_i  = 1'b0;
endtask

// --------------------------------------------------
// R and B return by ID[3:2]
// --------------------------------------------------
task automatic responses_by_id();
    logic [3:0] ids [4];
    int         dst [4];
    ids = '{4'b0001, 4'b1010, 4'b1101, 4'b0110};
    dst = '{0, 1, 2, 2};  // 01 goes to dcache
    for (int round = 0; round < 2; round++) begin
        for (int n = 0; n < 4; n++) begin
            @(negedge clk_i);
            m_r_valid_i   = 1'b1;
            m_r_id_i      = ids[n];
            m_r_data_i    = {rand32(), rand32()};
            m_r_resp_i    = 2'(rand32());
            m_r_last_i    = 1'(rand32());
            m_b_valid_i   = 1'b1;
            m_b_id_i      = ids[n];
            m_b_resp_i    = 2'(rand32());
            src_r_ready_i = (round == 0) ? onehot(dst[n]) : ~onehot(dst[n]);
            src_b_ready_i = src_r_ready_i;
            #1;
            expect_eq(64'(src_r_valid_o), 64'(onehot(dst[n])), "R valid routing");
            expect_eq(src_r_data_o, m_r_data_i, "R data");
            expect_eq(64'({src_r_id_o, src_r_resp_o, src_r_last_o}),
                      64'({m_r_id_i, m_r_resp_i, m_r_last_i}), "R id, resp and last");
            expect_eq(64'(m_r_ready_o), 64'(round == 0), "R ready from addressed source");
            expect_eq(64'(src_b_valid_o), 64'(onehot(dst[n])), "B valid routing");
            expect_eq(64'({src_b_id_o, src_b_resp_o}), 64'({m_b_id_i, m_b_resp_i}), "B payload");
            expect_eq(64'(m_b_ready_o), 64'(round == 0), "B ready from addressed source");
        end
    end
    @(negedge clk_i);
    m_r_valid_i   = 1'b0;
    m_b_valid_i   = 1'b0;
    src_r_ready_i = '0;
    src_b_ready_i = '0;
endtask

`endif

// File: verif/tb_axi_master_mux.sv
/*
 * Directed testbench for the three-source AXI master mux.
 * The test tasks model the sources and the memory side. There is no memory model.
 * Inputs change on the falling edge and outputs are sampled 1 ns later.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mux_defs.svh"

module tb_axi_master_mux;

    localparam int TEST_CYCLES     = 100;               // rough sum over all tests
    localparam int WATCHDOG_CYCLES = 20 * TEST_CYCLES;  // generous margin

    logic                           clk_i;
    logic                           arst_n_i;
    // source side
    logic [`N_SRC-1:0]              src_ar_valid_i, src_ar_ready_o;
    logic [`N_SRC-1:0]              src_aw_valid_i, src_aw_ready_o;
    logic [`N_SRC-1:0][`ID_W-1:0]   src_ar_id_i, src_aw_id_i;
    logic [`N_SRC-1:0][`ADDR_W-1:0] src_ar_addr_i, src_aw_addr_i;
    logic [`N_SRC-1:0][`LEN_W-1:0]  src_ar_len_i, src_aw_len_i;
    logic [`N_SRC-1:0]              src_w_valid_i, src_w_last_i, src_w_ready_o;
    logic [`N_SRC-1:0][`DATA_W-1:0] src_w_data_i;
    logic [`N_SRC-1:0][`STRB_W-1:0] src_w_strb_i;
    logic [`N_SRC-1:0]              src_r_valid_o, src_r_ready_i;
    logic [`N_SRC-1:0]              src_b_valid_o, src_b_ready_i;
    logic [`ID_W-1:0]               src_r_id_o, src_b_id_o;
    logic [`DATA_W-1:0]             src_r_data_o;
    logic [1:0]                     src_r_resp_o, src_b_resp_o;
    logic                           src_r_last_o;
    // master side
    logic                           m_ar_valid_o, m_ar_ready_i, m_aw_valid_o, m_aw_ready_i;
    logic                           m_w_valid_o, m_w_last_o, m_w_ready_i;
    logic [`ID_W-1:0]               m_ar_id_o, m_aw_id_o, m_r_id_i, m_b_id_i;
    logic [`ADDR_W-1:0]             m_ar_addr_o, m_aw_addr_o;
    logic [`LEN_W-1:0]              m_ar_len_o, m_aw_len_o;
    logic [`DATA_W-1:0]             m_w_data_o, m_r_data_i;
    logic [`STRB_W-1:0]             m_w_strb_o;
    logic                           m_r_valid_i, m_r_last_i, m_r_ready_o;
    logic                           m_b_valid_i, m_b_ready_o;
    logic [1:0]                     m_r_resp_i, m_b_resp_i;

    int     errors;
    int     checks;
    integer seed;

    axi_master_mux dut_i (.*);

    always #2 clk_i = ~clk_i;  // 4 ns period

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic logic [2:0] onehot(input int s);
        return 3'(1 << s);
    endfunction

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    task automatic expect_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic drive_idle();
        {src_ar_valid_i, src_ar_id_i, src_ar_addr_i, src_ar_len_i} = '0;
        {src_aw_valid_i, src_aw_id_i, src_aw_addr_i, src_aw_len_i} = '0;
        {src_w_valid_i, src_w_data_i, src_w_strb_i, src_w_last_i} = '0;
        {src_r_ready_i, src_b_ready_i} = '0;
        {m_ar_ready_i, m_aw_ready_i, m_w_ready_i} = '0;
        {m_r_valid_i, m_r_id_i, m_r_data_i, m_r_resp_i, m_r_last_i} = '0;
        {m_b_valid_i, m_b_id_i, m_b_resp_i} = '0;
    endtask

    `include "tb_tasks.svh"

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("watchdog expired, tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : main_seq
        seed     = 32'h348810aa;
        errors   = 0;
        checks   = 0;
        clk_i    = 1'b0;
        arst_n_i = 1'b0;
        drive_idle();
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;

        reset_state_idle();
        ar_round_robin();
        ar_stall_holds_grant();
        w_follows_aw_order();
        aw_stops_when_full();
        responses_by_id();

        $display("closing: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/axi_master_mux.sv
/*
 * Joins icache (0), bypass (1) and dcache (2) AXI masters onto one port.
 * AR and AW are arbitrated round-robin; R and B return by ID[3:2].
 * At most W_FIFO_DEPTH writes may be open; further AWs are stalled.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mux_defs.svh"

module axi_master_mux (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    // source AR
    input  logic [`N_SRC-1:0]                   src_ar_valid_i,
    input  logic [`N_SRC-1:0][`ID_W-1:0]        src_ar_id_i,
    input  logic [`N_SRC-1:0][`ADDR_W-1:0]      src_ar_addr_i,
    input  logic [`N_SRC-1:0][`LEN_W-1:0]       src_ar_len_i,
    output logic [`N_SRC-1:0]                   src_ar_ready_o,
    // source AW
    input  logic [`N_SRC-1:0]                   src_aw_valid_i,
    input  logic [`N_SRC-1:0][`ID_W-1:0]        src_aw_id_i,
    input  logic [`N_SRC-1:0][`ADDR_W-1:0]      src_aw_addr_i,
    input  logic [`N_SRC-1:0][`LEN_W-1:0]       src_aw_len_i,
    output logic [`N_SRC-1:0]                   src_aw_ready_o,
    // source W
    input  logic [`N_SRC-1:0]                   src_w_valid_i,
    input  logic [`N_SRC-1:0][`DATA_W-1:0]      src_w_data_i,
    input  logic [`N_SRC-1:0][`STRB_W-1:0]      src_w_strb_i,
    input  logic [`N_SRC-1:0]                   src_w_last_i,
    output logic [`N_SRC-1:0]                   src_w_ready_o,
    // source R, payload shared
    output logic [`N_SRC-1:0]                   src_r_valid_o,
    output logic [`ID_W-1:0]                    src_r_id_o,
    output logic [`DATA_W-1:0]                  src_r_data_o,
    output logic [1:0]                          src_r_resp_o,
    output logic                                src_r_last_o,
    input  logic [`N_SRC-1:0]                   src_r_ready_i,
    // source B, payload shared
    output logic [`N_SRC-1:0]                   src_b_valid_o,
    output logic [`ID_W-1:0]                    src_b_id_o,
    output logic [1:0]                          src_b_resp_o,
    input  logic [`N_SRC-1:0]                   src_b_ready_i,
    // master AR / AW / W
    output logic                                m_ar_valid_o,
    output logic [`ID_W-1:0]                    m_ar_id_o,
    output logic [`ADDR_W-1:0]                  m_ar_addr_o,
    output logic [`LEN_W-1:0]                   m_ar_len_o,
    input  logic                                m_ar_ready_i,
    output logic                                m_aw_valid_o,
    output logic [`ID_W-1:0]                    m_aw_id_o,
    output logic [`ADDR_W-1:0]                  m_aw_addr_o,
    output logic [`LEN_W-1:0]                   m_aw_len_o,
    input  logic                                m_aw_ready_i,
    output logic                                m_w_valid_o,
    output logic [`DATA_W-1:0]                  m_w_data_o,
    output logic [`STRB_W-1:0]                  m_w_strb_o,
    output logic                                m_w_last_o,
    input  logic                                m_w_ready_i,
    // master R / B
    input  logic                                m_r_valid_i,
    input  logic [`ID_W-1:0]                    m_r_id_i,
    input  logic [`DATA_W-1:0]                  m_r_data_i,
    input  logic [1:0]                          m_r_resp_i,
    input  logic                                m_r_last_i,
    output logic                                m_r_ready_o,
    input  logic                                m_b_valid_i,
    input  logic [`ID_W-1:0]                    m_b_id_i,
    input  logic [1:0]                          m_b_resp_i,
    output logic                                m_b_ready_o
);
    import axi_chan_pkg::*;

    addr_chan_t ar_src [`N_SRC];
    addr_chan_t aw_src [`N_SRC];
    w_chan_t    w_src  [`N_SRC];
    addr_chan_t ar_m;
    addr_chan_t aw_m;
    w_chan_t    w_m;
    r_chan_t    r_m;
    r_chan_t    r_src;
    b_chan_t    b_m;
    b_chan_t    b_src;
    logic       aw_ready_gated;  // master AW ready, cut while FIFO full

    // -------------------------------------------------
    // pack source requests
    // -------------------------------------------------
    for (genvar s = 0; s < `N_SRC; s++) begin : g_pack
        assign ar_src[s] = '{id: src_ar_id_i[s], addr: src_ar_addr_i[s], len: src_ar_len_i[s]};
        assign aw_src[s] = '{id: src_aw_id_i[s], addr: src_aw_addr_i[s], len: src_aw_len_i[s]};
        assign w_src[s]  = '{data: src_w_data_i[s], strb: src_w_strb_i[s], last: src_w_last_i[s]};
    end

    // -------------------------------------------------
    // request channels
    // -------------------------------------------------
    req_arbiter #(.payload_t(addr_chan_t)) u_ar_arb (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .src_valid_i   (src_ar_valid_i),
        .src_payload_i (ar_src),
        .src_ready_o   (src_ar_ready_o),
        .dst_valid_o   (m_ar_valid_o),
        .dst_payload_o (ar_m),
        .dst_ready_i   (m_ar_ready_i)
    );

    req_arbiter #(.payload_t(addr_chan_t)) u_aw_arb (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .src_valid_i   (src_aw_valid_i),
        .src_payload_i (aw_src),
        .src_ready_o   (src_aw_ready_o),
        .dst_valid_o   (m_aw_valid_o),
        .dst_payload_o (aw_m),
        .dst_ready_i   (aw_ready_gated)
    );

    w_route_buffer u_w_route (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .aw_valid_i      (m_aw_valid_o),
        .aw_id_i         (aw_m.id),
        .aw_ready_i      (m_aw_ready_i),
        .aw_ready_o      (aw_ready_gated),
        .src_w_valid_i   (src_w_valid_i),
        .src_w_payload_i (w_src),
        .src_w_ready_o   (src_w_ready_o),
        .m_w_valid_o     (m_w_valid_o),
        .m_w_payload_o   (w_m),
        .m_w_ready_i     (m_w_ready_i)
    );

    assign {m_ar_id_o, m_ar_addr_o, m_ar_len_o} = {ar_m.id, ar_m.addr, ar_m.len};
    assign {m_aw_id_o, m_aw_addr_o, m_aw_len_o} = {aw_m.id, aw_m.addr, aw_m.len};
    assign {m_w_data_o, m_w_strb_o, m_w_last_o} = {w_m.data, w_m.strb, w_m.last};

    // -------------------------------------------------
    // response channels
    // -------------------------------------------------
    assign r_m = '{id: m_r_id_i, data: m_r_data_i, resp: m_r_resp_i, last: m_r_last_i};
    assign b_m = '{id: m_b_id_i, resp: m_b_resp_i};

    resp_router #(.payload_t(r_chan_t)) u_r_route (
        .m_valid_i     (m_r_valid_i),
        .m_payload_i   (r_m),
        .m_id_i        (m_r_id_i),
        .m_ready_o     (m_r_ready_o),
        .src_valid_o   (src_r_valid_o),
        .src_payload_o (r_src),
        .src_ready_i   (src_r_ready_i)
    );

    resp_router #(.payload_t(b_chan_t)) u_b_route (
        .m_valid_i     (m_b_valid_i),
        .m_payload_i   (b_m),
        .m_id_i        (m_b_id_i),
        .m_ready_o     (m_b_ready_o),
        .src_valid_o   (src_b_valid_o),
        .src_payload_o (b_src),
        .src_ready_i   (src_b_ready_i)
    );

    assign {src_r_id_o, src_r_data_o, src_r_resp_o, src_r_last_o} =
        {r_src.id, r_src.data, r_src.resp, r_src.last};
    assign {src_b_id_o, src_b_resp_o} = {b_src.id, b_src.resp};

endmodule

`default_nettype wire

// File: hdl/resp_router.sv
/*
 * Steers one response channel (R or B) back to its source.
 * The payload is broadcast; only valid and ready are routed.
 * Purely combinational.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mux_defs.svh"

module resp_router #(
    parameter type payload_t = axi_chan_pkg::b_chan_t
) (
    // master side
    input  logic              m_valid_i,
    input  payload_t          m_payload_i,
    input  logic [`ID_W-1:0]  m_id_i,
    output logic              m_ready_o,
    // source side
    output logic [`N_SRC-1:0] src_valid_o,
    output payload_t          src_payload_o,
    input  logic [`N_SRC-1:0] src_ready_i
);
    import mux_route_pkg::*;

    src_idx_t dst;

    assign dst = id_to_src(m_id_i);

    // -------------------------------------------------
    // only the addressed source sees valid
    // -------------------------------------------------
    always_comb begin
        src_valid_o      = '0;
        src_valid_o[dst] = m_valid_i;
    end

    assign m_ready_o     = src_ready_i[dst];  // that source paces the master
    assign src_payload_o = m_payload_i;

endmodule

`default_nettype wire

// File: hdl/w_route_buffer.sv
/*
 * Routes W beats in the order of accepted AWs (AXI4 has no WID).
 * W for an AW can pass from the cycle after the AW transfer.
 * AW is held back while W_FIFO_DEPTH writes are still open.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mux_defs.svh"

module w_route_buffer (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    // AW observed between arbiter and master
    input  logic                  aw_valid_i,
    input  logic [`ID_W-1:0]      aw_id_i,
    input  logic                  aw_ready_i,   // from master
    output logic                  aw_ready_o,   // to AW arbiter
    // source W
    input  logic [`N_SRC-1:0]     src_w_valid_i,
    input  axi_chan_pkg::w_chan_t src_w_payload_i [`N_SRC],
    output logic [`N_SRC-1:0]     src_w_ready_o,
    // master W
    output logic                  m_w_valid_o,
    output axi_chan_pkg::w_chan_t m_w_payload_o,
    input  logic                  m_w_ready_i
);
    import mux_route_pkg::*;

    localparam int PTR_W = $clog2(`W_FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = `W_FIFO_DEPTH;

    src_idx_t         fifo_mem [`W_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             fifo_full;
    logic             fifo_empty;
    logic             push;
    logic             pop;
    src_idx_t         head_src;

    assign fifo_full  = (count_q == FULL_CNT);
    assign fifo_empty = (count_q == '0);
    assign head_src   = fifo_mem[rd_ptr_q];

    // -------------------------------------------------
    // AW side
    // -------------------------------------------------
    assign aw_ready_o = aw_ready_i & ~fifo_full;
    assign push       = aw_valid_i & aw_ready_o;

    // -------------------------------------------------
    // W mux, driven by the oldest open write
    // -------------------------------------------------
    assign m_w_valid_o   = ~fifo_empty & src_w_valid_i[head_src];
    assign m_w_payload_o = src_w_payload_i[head_src];

    always_comb begin
        src_w_ready_o = '0;
        if (!fifo_empty) begin
            src_w_ready_o[head_src] = m_w_ready_i;
        end
    end

    assign pop = m_w_valid_o & m_w_ready_i & m_w_payload_o.last;  // burst done

    // -------------------------------------------------
    // FIFO storage and pointers
    // -------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= id_to_src(aw_id_i);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps, depth is a power of two
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/req_arbiter.sv
/*
 * Round-robin valid/ready arbiter, combinational from source to destination.
 * A source must hold valid and payload stable until its transfer happens.
 * The grant is locked while the output waits on dst_ready_i.
 */
`timescale 1ns/1ps
`default_nettype none

`include "mux_defs.svh"

module req_arbiter #(
    parameter type payload_t = axi_chan_pkg::addr_chan_t
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    // source side
    input  logic [`N_SRC-1:0]   src_valid_i,
    input  payload_t            src_payload_i [`N_SRC],
    output logic [`N_SRC-1:0]   src_ready_o,
    // destination side
    output logic                dst_valid_o,
    output payload_t            dst_payload_o,
    input  logic                dst_ready_i
);
    import mux_route_pkg::*;

    src_idx_t ptr_q;    // highest priority source
    src_idx_t grant_q;  // held grant under back-pressure
    logic     lock_q;
    src_idx_t cand;
    src_idx_t sel;

    // -------------------------------------------------
    // search from the pointer, nearest valid wins
    // -------------------------------------------------
    always_comb begin
        int idx;
        cand = ptr_q;
        for (int k = `N_SRC - 1; k >= 0; k--) begin  // walk back so offset 0 lands last
            idx = (int'(ptr_q) + k) % `N_SRC;
            if (src_valid_i[idx]) begin
                cand = src_idx_t'(idx);
            end
        end
    end

    assign sel           = lock_q ? grant_q : cand;
    assign dst_valid_o   = src_valid_i[sel];
    assign dst_payload_o = src_payload_i[sel];

    always_comb begin
        src_ready_o      = '0;
        src_ready_o[sel] = dst_valid_o & dst_ready_i;  // only the winner sees ready
    end

    // -------------------------------------------------
    // pointer and lock
    // -------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q   <= SRC_ICACHE;
            grant_q <= SRC_ICACHE;
            lock_q  <= 1'b0;
        end else if (dst_valid_o && dst_ready_i) begin
            ptr_q  <= src_idx_t'((int'(sel) + 1) % `N_SRC);  // one past the winner
            lock_q <= 1'b0;
        end else if (dst_valid_o) begin
            grant_q <= sel;  // stalled, keep this source
            lock_q  <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mux_route_pkg.sv
/*
 * Source numbering and the ID-based return routing.
 * ID prefix 01 is not issued by any source; it is sent to the dcache.
 */
`default_nettype none

`include "mux_defs.svh"

package mux_route_pkg;

    typedef logic [$clog2(`N_SRC)-1:0] src_idx_t;

    localparam src_idx_t SRC_ICACHE = 0;
    localparam src_idx_t SRC_BYPASS = 1;
    localparam src_idx_t SRC_DCACHE = 2;

    // -------------------------------------------------
    // top two ID bits name the issuing source
    function automatic src_idx_t id_to_src(input logic [`ID_W-1:0] id);
        src_idx_t src;
        case (id[`ID_W-1 -: 2])
            2'b00:   src = SRC_ICACHE;
            2'b10:   src = SRC_BYPASS;
            default: src = SRC_DCACHE;  // 11, and stray 01
        endcase
        return src;
    endfunction

endpackage

`default_nettype wire

// File: hdl/axi_chan_pkg.sv
/*
 * AXI channel payloads without valid/ready.
 * AR and AW share one struct, as neither carries extra attributes here.
 */
`default_nettype none

`include "mux_defs.svh"

package axi_chan_pkg;

    // -------------------------------------------------
    // request side
    // -------------------------------------------------
    typedef struct packed {
        logic [`ID_W-1:0]   id;
        logic [`ADDR_W-1:0] addr;
        logic [`LEN_W-1:0]  len;   // beats minus one
    } addr_chan_t;

    typedef struct packed {
        logic [`DATA_W-1:0] data;
        logic [`STRB_W-1:0] strb;
        logic               last;
    } w_chan_t;

    // -------------------------------------------------
    // response side
    // -------------------------------------------------
    typedef struct packed {
        logic [`ID_W-1:0]   id;
        logic [`DATA_W-1:0] data;
        logic [1:0]         resp;
        logic               last;
    } r_chan_t;

    typedef struct packed {
        logic [`ID_W-1:0] id;
        logic [1:0]       resp;
    } b_chan_t;

endpackage

`default_nettype wire

// File: hdl/mux_defs.svh
/*
 * Widths and sizes for the three-source AXI master mux.
 * W_FIFO_DEPTH must be a power of two, since the FIFO pointers wrap naturally.
 * The top two ID bits select the source, so ID_W must be at least 2.
 */
`ifndef MUX_DEFS_SVH
`define MUX_DEFS_SVH

`define ADDR_W       32
`define DATA_W       64
`define STRB_W       (`DATA_W / 8)
`define ID_W         4
`define LEN_W        8

// -------------------------------------------------
`define N_SRC        3  // icache, bypass, dcache
`define W_FIFO_DEPTH 4  // outstanding writes

`endif
